// ==== include/encoder_cfg_cfg.svh ====
// build-time constants for the composite encoder, included by the FIFO, modulator and top
`ifndef ENCODER_CFG_CFG_SVH
`define ENCODER_CFG_CFG_SVH

// entry buffer between mapper and modulator
// must be a power of two so the pointers wrap on their own
`define ENC_FIFO_DEPTH 4

// colour burst shape, used for sync words with the burst flag set
// amplitude multiplies the sine table, so 2 gives a swing of +-14 around 32
`define ENC_BURST_AMP 2'd2

// burst phase in sixteenths of a carrier cycle
// 8 is half a cycle, i.e. 180 degrees from the reference
`define ENC_BURST_PHASE 4'd8

// notes on the sample rate
// one carrier cycle is 16 clocks of clk_col16x_ntsc
// one pixel item is consumed per carrier cycle
// so a full fifo holds ENC_FIFO_DEPTH * 16 clocks of video

`endif

// ==== source/encoder_pkg.sv ====
// shared types and the sine table for the encoder; imported by every block that handles entries
`default_nettype none

package encoder_pkg;

   // colour view of a palette entry
   typedef struct packed {
      logic [5:0] luma;   // luma level
      logic [3:0] phase;  // chroma phase, 1/16 carrier steps
      logic [1:0] amp;    // chroma amplitude 0..3
   } color_entry_t;

   // sync/blank view, same 12 bits
   typedef struct packed {
      logic [5:0] level;  // luma level during sync or blank
      logic       burst;  // emit colour burst on chroma
      logic [4:0] pad;    // unused, kept zero
   } sync_entry_t;

   // one word, two decodes
   typedef union packed {
      color_entry_t color;
      sync_entry_t  sync;
   } entry_word_u;

   typedef struct packed {
      logic        is_sync;  // picks the union view
      entry_word_u word;
   } video_entry_t;

   // quarter-symmetric sine, 16 steps per cycle, peak 7
   function automatic logic signed [3:0] sine16(input logic [3:0] step);
      logic signed [3:0] tbl [16];
      tbl = '{4'sd0, 4'sd3, 4'sd5, 4'sd6, 4'sd7, 4'sd6, 4'sd5, 4'sd3,
              4'sd0, -4'sd3, -4'sd5, -4'sd6, -4'sd7, -4'sd6, -4'sd5, -4'sd3};
      return tbl[step];
   endfunction

endpackage

`default_nettype wire

// ==== source/entry_stream_if.sv ====
// ready/valid link for video entries, used mapper->fifo and fifo->modulator
`default_nettype none

interface entry_stream_if
   import encoder_pkg::*;
();

   logic         valid;  // entry is offered
   logic         ready;  // sink takes it this edge
   video_entry_t entry;  // held stable until ready

   // producer side
   modport source (
      output valid,
      output entry,
      input  ready
   );

   // consumer side
   modport sink (
      input  valid,
      input  entry,
      output ready
   );

endinterface

`default_nettype wire

// ==== source/palette_mapper.sv ====
// producer: holds the host-written palette and turns pixel items into video entries
`default_nettype none

module palette_mapper
   import encoder_pkg::*;
(
   input  wire logic       clk_col16x_ntsc,
   input  wire logic       rst,
   // host register bus
   input  wire logic       ce,         // chip enable, low active
   input  wire logic       rw,         // low = write
   input  wire logic [4:0] adr,        // [3:0] colour index, [4] half select
   input  wire logic [7:0] dbi,        // write data
   // pixel stream
   input  wire logic       pix_valid,
   input  wire logic       pix_sync,   // item is a sync/blank word
   input  wire logic [7:0] pix_data,
   output logic            pix_ready,
   entry_stream_if.source  ent
);

   color_entry_t palette [16];   // 16 colour registers
   logic         host_wr;        // write strobe this edge
   logic [3:0]   wr_idx;
   logic [3:0]   pix_idx;

   assign host_wr = !ce && !rw;   // no wait state, any edge
   assign wr_idx  = adr[3:0];
   assign pix_idx = pix_data[3:0];

   // palette registers
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         for (int i = 0; i < 16; i++)
         begin
            palette[i] <= '0;
         end
      end
      else if (host_wr)
      begin
         if (adr[4])
         begin
            palette[wr_idx].phase <= dbi[3:0];   // upper half, phase only
         end
         else
         begin
            palette[wr_idx].luma <= dbi[5:0];    // lower half, luma + amp
            palette[wr_idx].amp  <= dbi[7:6];
         end
      end
   end

   // no storage here, the fifo does the buffering
   assign ent.valid = pix_valid;
   assign pix_ready = ent.ready;   // fifo back-pressure straight through

   // build the entry from the item
   always_comb
   begin
      ent.entry.is_sync = pix_sync;
      if (pix_sync)
      begin
         ent.entry.word.sync.level = pix_data[5:0];
         ent.entry.word.sync.burst = pix_data[6];
         ent.entry.word.sync.pad   = '0;
      end
      else
      begin
         ent.entry.word.color = palette[pix_idx];   // palette lookup
      end
   end

   // an offered item must not change while the fifo stalls it
   a_pix_hold : assert property (
      @(posedge clk_col16x_ntsc) disable iff (rst)
      (pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_data) && $stable(pix_sync))
   );

endmodule

`default_nettype wire

// ==== source/entry_fifo.sv ====
// buffer: synchronous entry FIFO with ready/valid on both sides, sits between mapper and modulator
`default_nettype none

`include "encoder_cfg_cfg.svh"

module entry_fifo
   import encoder_pkg::*;
#(
   parameter int DEPTH = `ENC_FIFO_DEPTH   // power of two
)
(
   input  wire logic      clk_col16x_ntsc,
   input  wire logic      rst,
   entry_stream_if.sink   wr,   // from the mapper
   entry_stream_if.source rd    // to the modulator
);

   localparam int AW = $clog2(DEPTH);

   video_entry_t   mem [DEPTH];   // entry storage
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [AW:0]    count;         // 0..DEPTH
   logic           full;
   logic           push;
   logic           pop;

   assign full  = count == (AW+1)'(DEPTH);
   assign pop   = rd.valid && rd.ready;
   // a pop frees a slot on the same edge, so a full fifo still takes one
   assign wr.ready = !full || pop;
   assign push  = wr.valid && wr.ready;

   assign rd.valid = count != '0;
   assign rd.entry = mem[rd_ptr];   // head of queue

   // pointers and fill level
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)      count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   // storage
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (push) mem[wr_ptr] <= wr.entry;
   end

   a_count_max : assert property (
      @(posedge clk_col16x_ntsc) disable iff (rst) count <= (AW+1)'(DEPTH)
   );

   // when empty the read pointer sits on the write pointer and never runs past it
   a_no_underflow : assert property (
      @(posedge clk_col16x_ntsc) disable iff (rst) (count == '0) |-> (rd_ptr == wr_ptr)
   );

endmodule

`default_nettype wire

// ==== source/chroma_modulator.sv ====
// consumer: phase counter, per-cycle entry loader and registered luma/chroma sample generation
`default_nettype none

`include "encoder_cfg_cfg.svh"

module chroma_modulator
   import encoder_pkg::*;
(
   input  wire logic      clk_col16x_ntsc,
   input  wire logic      rst,
   entry_stream_if.sink   ent,         // from the fifo
   output logic [5:0]     luma,
   output logic [5:0]     chroma,      // centred on 32
   output logic           luma_sink    // current sink during sync
);

   logic [3:0]        cnt;         // carrier phase, 16 per cycle
   logic              wrap;        // last clock of the cycle
   video_entry_t      cur;         // entry for the running cycle
   logic              cur_valid;   // low = blank cycle
   video_entry_t      sel;
   logic              sel_valid;
   logic [1:0]        amp_sel;
   logic [3:0]        ph_sel;
   logic [3:0]        step;
   logic signed [3:0] sin_val;
   logic signed [6:0] mod_prod;
   logic [5:0]        luma_nxt;
   logic [5:0]        chroma_nxt;
   logic              sink_nxt;

   assign wrap      = cnt == 4'd15;
   assign ent.ready = wrap;   // only pop at the wrap

   // counter and loader
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         cnt       <= 4'd0;
         cur_valid <= 1'b0;
      end
      else
      begin
         cnt <= cnt + 4'd1;
         if (wrap) cur_valid <= ent.valid;   // nothing there -> blank cycle
      end
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (wrap && ent.valid) cur <= ent.entry;
   end

   // outputs are registered, so compute the sample for cnt+1
   // at the wrap that is sample 0 of the entry being popped
   always_comb
   begin
      sel       = wrap ? ent.entry : cur;
      sel_valid = wrap ? ent.valid : cur_valid;
      luma_nxt  = 6'd0;
      sink_nxt  = 1'b0;
      amp_sel   = 2'd0;   // zero amplitude = flat 32
      ph_sel    = 4'd0;
      if (sel_valid && sel.is_sync)
      begin
         luma_nxt = sel.word.sync.level;
         sink_nxt = 1'b1;
         amp_sel  = sel.word.sync.burst ? `ENC_BURST_AMP : 2'd0;
         ph_sel   = `ENC_BURST_PHASE;
      end
      else if (sel_valid)
      begin
         luma_nxt = sel.word.color.luma;
         amp_sel  = sel.word.color.amp;
         ph_sel   = sel.word.color.phase;
      end
      step       = cnt + 4'd1 + ph_sel;   // modulo 16
      sin_val    = sine16(step);
      mod_prod   = $signed({1'b0, amp_sel}) * sin_val;   // -21..21
      chroma_nxt = 6'd32 + mod_prod[5:0];
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         luma      <= 6'd0;
         chroma    <= 6'd32;   // blank level
         luma_sink <= 1'b0;
      end
      else
      begin
         luma      <= luma_nxt;
         chroma    <= chroma_nxt;
         luma_sink <= sink_nxt;
      end
   end

   // 32 +- 3*7 at most
   a_chroma_range : assert property (
      @(posedge clk_col16x_ntsc) disable iff (rst) (chroma >= 6'd11) && (chroma <= 6'd53)
   );

endmodule

`default_nettype wire

// ==== source/composite_encoder_top.sv ====
// top level of the composite encoder: host bus and pixel stream in, luma/chroma pins out
`default_nettype none

`include "encoder_cfg_cfg.svh"

module composite_encoder_top (
   input  wire logic       clk_col16x_ntsc,   // 16 samples per carrier cycle
   input  wire logic       rst,
   input  wire logic       ce,                // chip enable, low active
   input  wire logic       rw,                // low = write
   input  wire logic [4:0] adr,
   input  wire logic [7:0] dbi,
   input  wire logic       pix_valid,
   input  wire logic       pix_sync,
   input  wire logic [7:0] pix_data,
   output logic            pix_ready,
   output logic [5:0]      luma,
   output logic [5:0]      chroma,
   output logic            luma_sink
);

   entry_stream_if ent_in ();    // mapper -> fifo
   entry_stream_if ent_out ();   // fifo -> modulator

   palette_mapper u_mapper (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .ce              (ce),
      .rw              (rw),
      .adr             (adr),
      .dbi             (dbi),
      .pix_valid       (pix_valid),
      .pix_sync        (pix_sync),
      .pix_data        (pix_data),
      .pix_ready       (pix_ready),
      .ent             (ent_in)
   );

   entry_fifo #(.DEPTH(`ENC_FIFO_DEPTH)) u_fifo (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .wr              (ent_in),
      .rd              (ent_out)
   );

   chroma_modulator u_mod (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .ent             (ent_out),
      .luma            (luma),
      .chroma          (chroma),
      .luma_sink       (luma_sink)
   );

endmodule

`default_nettype wire

// ==== bench/composite_encoder_tb.sv ====
// testbench for the composite encoder top, replays the records of bench/encoder_cases.txt
`default_nettype none

module composite_encoder_tb;

   logic       clk_col16x_ntsc = 1'b0;
   logic       rst;
   logic       ce;
   logic       rw;
   logic [4:0] adr;
   logic [7:0] dbi;
   logic       pix_valid;
   logic       pix_sync;
   logic [7:0] pix_data;
   logic       pix_ready;
   logic [5:0] luma;
   logic [5:0] chroma;
   logic       luma_sink;

   // records as read, one slot per line
   logic [7:0]  rec_kind [$];
   int          rec_a [$];
   int          rec_b [$];
   logic [95:0] rec_wave [$];   // 16 chroma samples, sample 0 lowest

   // colour cycles still to be seen on the pins
   logic [5:0]  exp_luma [$];
   logic        exp_sink [$];
   logic [95:0] exp_wave [$];

   logic [5:0]  cur_luma;
   logic        cur_sink;
   logic [95:0] cur_wave;
   int          phase;         // bench copy of the carrier counter
   int          cycles;
   int          cycle_limit;
   integer      seed;

   composite_encoder_top UUT (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .ce              (ce),
      .rw              (rw),
      .adr             (adr),
      .dbi             (dbi),
      .pix_valid       (pix_valid),
      .pix_sync        (pix_sync),
      .pix_data        (pix_data),
      .pix_ready       (pix_ready),
      .luma            (luma),
      .chroma          (chroma),
      .luma_sink       (luma_sink)
   );

   always #10 clk_col16x_ntsc = ~clk_col16x_ntsc;   // period 20

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_sample(input logic [5:0] want_luma, input logic [5:0] want_chroma,
                               input logic want_sink);
      if (luma !== want_luma)
      begin
         $display("error luma: got %h, expected %h (sample %0d)", luma, want_luma, phase);
         abort_run();
      end
      if (chroma !== want_chroma)
      begin
         $display("error chroma: got %h, expected %h (sample %0d)", chroma, want_chroma, phase);
         abort_run();
      end
      if (luma_sink !== want_sink)
      begin
         $display("error luma_sink: got %h, expected %h (sample %0d)", luma_sink, want_sink,
                  phase);
         abort_run();
      end
   endtask

   task automatic check_ready(input logic want_ready);
      if (pix_ready !== want_ready)
      begin
         $display("error pix_ready: got %h, expected %h", pix_ready, want_ready);
         abort_run();
      end
   endtask

   // check the sample shown at this falling edge, then move to the next one
   task automatic sample_and_advance();
      if (phase == 0)
      begin
         if (exp_luma.size() > 0)
         begin
            cur_luma = exp_luma.pop_front();
            cur_sink = exp_sink.pop_front();
            cur_wave = exp_wave.pop_front();
         end
         else
         begin
            cur_luma = 6'h00;          // fifo ran dry, blank cycle
            cur_sink = 1'b0;
            cur_wave = {16{6'h20}};
         end
      end
      check_sample(cur_luma, cur_wave[phase*6 +: 6], cur_sink);
      phase  = (phase + 1) % 16;
      cycles = cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         abort_run();
      end
      @(negedge clk_col16x_ntsc);
   endtask

   // run out every queued cycle and stop on a cycle boundary
   task automatic drain_expected();
      while (exp_luma.size() > 0 || phase != 0)
         sample_and_advance();
   endtask

   task automatic write_palette(input logic [4:0] wr_adr, input logic [7:0] wr_data);
      ce  = 1'b0;
      rw  = 1'b0;
      adr = wr_adr;
      dbi = wr_data;
      sample_and_advance();    // write lands on this rising edge
      ce  = 1'b1;
      rw  = 1'b1;
   endtask

   task automatic push_item(input logic sync, input logic [7:0] data);
      int gap;
      gap = $unsigned($random(seed)) % 2;   // short idle gap
      repeat (gap) sample_and_advance();
      pix_valid = 1'b1;
      pix_sync  = sync;
      pix_data  = data;
      while (pix_ready !== 1'b1)
         sample_and_advance();                // fifo full, hold the item
      sample_and_advance();                   // taken on this edge
      pix_valid = 1'b0;
   endtask

   task automatic load_cases();
      int               fd;
      int               n;
      int               a;
      int               b;
      int               c;
      logic             ok;
      logic             keep;
      logic             done;
      logic [7:0]       tok;
      logic [95:0]      wave;
      logic [8*128-1:0] line;
      fd = $fopen("bench/encoder_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the cases file bench/encoder_cases.txt");
         abort_run();
      end
      done = 1'b0;
      while (!done)
      begin
         tok  = 8'h00;
         a    = 0;
         b    = 0;
         wave = '0;
         ok   = 1'b1;
         keep = 1'b1;
         n    = $fscanf(fd, "%s", tok);
         if (n != 1)
            done = 1'b1;
         else
         begin
            case (tok)
               "#":
               begin
                  n    = $fgets(line, fd);    // column notes
                  keep = 1'b0;
               end
               "W", "P": ok = ($fscanf(fd, "%h %h", a, b) == 2);
               "F": ok = ($fscanf(fd, "%h", a) == 1);
               "R": ok = 1'b1;
               "E":
               begin
                  ok = ($fscanf(fd, "%h %h", a, b) == 2);
                  for (int i = 0; i < 16; i++)
                  begin
                     ok = ok && ($fscanf(fd, "%h", c) == 1);
                     wave[i*6 +: 6] = c[5:0];
                  end
               end
               default: ok = 1'b0;
            endcase
            if (!ok)
            begin
               $display("the cases file holds a malformed record of kind %s", tok);
               abort_run();
            end
            if (keep)
            begin
               rec_kind.push_back(tok);
               rec_a.push_back(a);
               rec_b.push_back(b);
               rec_wave.push_back(wave);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic run_record(input logic [7:0] kind, input int a, input int b,
                             input logic [95:0] wave);
      case (kind)
         "W": write_palette(a[4:0], b[7:0]);
         "P": push_item(a[0], b[7:0]);
         "F": check_ready(a[0]);
         "R": drain_expected();   // fifo empty before the next burst
         "E":
         begin
            exp_luma.push_back(a[5:0]);
            exp_sink.push_back(b[0]);
            exp_wave.push_back(wave);
         end
         default: ;
      endcase
   endtask

   initial
   begin
      rst       = 1'b1;
      ce        = 1'b1;
      rw        = 1'b1;
      adr       = 5'h00;
      dbi       = 8'h00;
      pix_valid = 1'b0;
      pix_sync  = 1'b0;
      pix_data  = 8'h00;
      seed      = 32'h0a40_4ca7;
      phase     = 0;
      cycles    = 0;
      load_cases();
      cycle_limit = (rec_kind.size() + 4) * 16 * 4;
      repeat (5) @(negedge clk_col16x_ntsc);
      rst = 1'b0;                             // counter shows 0 from here
      for (int r = 0; r < rec_kind.size(); r++)
         run_record(rec_kind[r], rec_a[r], rec_b[r], rec_wave[r]);
      drain_expected();
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/encoder_cases.txt ====
# kind and hex args: W adr data | P sync data | F pix_ready | R start a new burst
# E luma sink chroma0 .. chroma15, the expected samples of one colour cycle
F 1
E 00 0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
E 00 0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
W 01 70
W 11 00
W 02 d4
W 12 04
W 03 8a
W 13 0b
W 04 3f
W 14 05
# six items back to back, the fifo fills and stalls the stream
R
E 00 0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
E 30 0 20 23 25 26 27 26 25 23 20 1d 1b 1a 19 1a 1b 1d
E 14 0 35 32 2f 29 20 17 11 0e 0b 0e 11 17 20 29 2f 32
E 0a 0 14 12 14 16 1a 20 26 2a 2c 2e 2c 2a 26 20 1a 16
E 08 1 20 1a 16 14 12 14 16 1a 20 26 2a 2c 2e 2c 2a 26
E 02 1 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
E 3f 0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
P 0 01
P 0 02
P 0 03
P 1 48
F 0
P 1 02
P 0 04
# same index pushed before and after a palette rewrite
R
E 00 0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
E 30 0 20 23 25 26 27 26 25 23 20 1d 1b 1a 19 1a 1b 1d
E 25 0 20 26 2a 2c 2e 2c 2a 26 20 1a 16 14 12 14 16 1a
E 00 0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
P 0 01
W 01 a5
P 0 01

// ==== verilog.f ====
+incdir+include
source/encoder_pkg.sv
source/entry_stream_if.sv
source/palette_mapper.sv
source/entry_fifo.sv
source/chroma_modulator.sv
source/composite_encoder_top.sv
bench/composite_encoder_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = composite_encoder_tb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and search $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	-./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
